// File: rtl/l2_mem_settings.svh
/*
  Geometry of the L2 scratchpad and of the SRAM cuts it is built from.
  Included by the packages and by any RTL that checks the cut grid.
  Derived counts follow from the base values and must stay powers of two.
*/

`ifndef L2_MEM_SETTINGS_SVH
`define L2_MEM_SETTINGS_SVH

// Byte address width, 2 KiB of storage
`define L2_ADDR_W 11

// Width of the memory port
`define L2_DATA_W 64

// Total capacity in bytes
`define L2_N_BYTES 2048

// One cut, keep in line with the macro that gets placed
`define L2_CUT_DW 32
`define L2_CUT_N_WORDS 64

// Columns of cuts side by side to cover the port width
`define L2_N_PAR_CUTS (`L2_DATA_W / `L2_CUT_DW)

// Rows of cuts stacked to cover the capacity
`define L2_N_SER_CUTS (`L2_N_BYTES / (`L2_N_PAR_CUTS * `L2_CUT_N_WORDS * `L2_CUT_DW / 8))

// Power of two test for the cut grid
`define L2_IS_POW2(x) ((((x) & ((x) - 1)) == 0) && ((x) > 0))

`endif

// File: rtl/l2_arr_pkg.sv
/*
  Types seen at the memory port of the scratchpad.
  Also gives the positions of the word and row fields in a byte address.
*/

`include "l2_mem_settings.svh"

package l2_arr_pkg;

  localparam int unsigned ADDR_W = `L2_ADDR_W;
  localparam int unsigned DATA_W = `L2_DATA_W;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Number of cut rows
  localparam int unsigned N_SER_CUTS = `L2_N_SER_CUTS;

  localparam int unsigned WORD_IDX_W = $clog2(`L2_CUT_N_WORDS);
  localparam int unsigned ROW_IDX_W  = $clog2(N_SER_CUTS);

  // Byte offset bits sit below the word index, the row index on top
  localparam int unsigned WORD_IDX_OFF = $clog2(STRB_W);
  localparam int unsigned ROW_IDX_OFF  = WORD_IDX_OFF + WORD_IDX_W;

  typedef logic [ADDR_W-1:0]     arr_addr_t;
  typedef logic [DATA_W-1:0]     arr_data_t;
  typedef logic [STRB_W-1:0]     arr_strb_t;
  typedef logic [WORD_IDX_W-1:0] word_idx_t;
  typedef logic [ROW_IDX_W-1:0]  row_idx_t;

endpackage

// File: rtl/l2_cut_pkg.sv
/*
  Types of a single SRAM cut and of the column bundle that forms one row.
  A row bundle is as wide as the memory port.
*/

`include "l2_mem_settings.svh"

package l2_cut_pkg;

  localparam int unsigned CUT_DW      = `L2_CUT_DW;
  localparam int unsigned CUT_STRB_W  = CUT_DW / 8;
  localparam int unsigned CUT_N_WORDS = `L2_CUT_N_WORDS;

  // Columns per row
  localparam int unsigned N_PAR_CUTS = `L2_N_PAR_CUTS;

  typedef logic [$clog2(CUT_N_WORDS)-1:0] cut_addr_t;
  typedef logic [CUT_DW-1:0]              cut_data_t;
  typedef logic [CUT_STRB_W-1:0]          cut_strb_t;

  // Column 0 holds the low bits of the port word
  typedef cut_data_t [N_PAR_CUTS-1:0] cut_row_data_t;
  typedef cut_strb_t [N_PAR_CUTS-1:0] cut_row_strb_t;

endpackage

// File: rtl/l2_mem_if.sv
/*
  Interfaces between the pipeline stages of the scratchpad.
  l2_cut_req_if carries a decoded request to the cut array, and the return
  stage watches it through the mon modport. l2_cut_rsp_if carries the read
  data of all rows back from the array.
*/

interface l2_cut_req_if
  import l2_arr_pkg::*, l2_cut_pkg::*;
();

  // One-hot, zero when idle
  logic [N_SER_CUTS-1:0] row_req;
  row_idx_t              row_idx;
  logic                  we;
  cut_addr_t             word_addr;
  cut_row_data_t         wdata;
  cut_row_strb_t         be;

  modport src (
    output row_req, row_idx, we, word_addr, wdata, be
  );

  modport dst (
    input row_req, row_idx, we, word_addr, wdata, be
  );

  // Return stage only needs to know which row is being accessed
  modport mon (
    input row_req, row_idx
  );

endinterface

interface l2_cut_rsp_if
  import l2_arr_pkg::*, l2_cut_pkg::*;
();

  cut_row_data_t [N_SER_CUTS-1:0] rdata;

  modport src (output rdata);
  modport dst (input rdata);

endinterface

// File: rtl/l2_req_decode.sv
/*
  Pipeline stage 1 of the scratchpad.
  Splits the byte address into word and row index, builds the one-hot row
  request and slices data and strobe per column. While idle the last word
  and row index are held so the macro address pins do not toggle.
*/

module l2_req_decode
  import l2_arr_pkg::*;
  import l2_cut_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  logic      we_i,
  input  arr_addr_t addr_i,
  input  arr_data_t wdata_i,
  input  arr_strb_t be_i,
  l2_cut_req_if.src cut_o
);

  word_idx_t             word_idx_d, word_idx_q;
  row_idx_t              row_idx_d, row_idx_q;
  logic [N_SER_CUTS-1:0] row_req;
  cut_row_data_t         col_wdata;
  cut_row_strb_t         col_be;

  // Take new fields only with a request
  assign word_idx_d = req_i ? addr_i[WORD_IDX_OFF +: WORD_IDX_W] : word_idx_q;
  assign row_idx_d  = req_i ? addr_i[ROW_IDX_OFF +: ROW_IDX_W] : row_idx_q;

  always_comb begin
    row_req            = '0;
    row_req[row_idx_d] = req_i;
  end

  // Column c gets its own slice of the port word
  always_comb begin
    for (int c = 0; c < N_PAR_CUTS; c++) begin
      col_wdata[c] = wdata_i[c*CUT_DW +: CUT_DW];
      col_be[c]    = be_i[c*CUT_STRB_W +: CUT_STRB_W];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_idx_q <= '0;
      row_idx_q  <= '0;
    end else begin
      word_idx_q <= word_idx_d;
      row_idx_q  <= row_idx_d;
    end
  end

  assign cut_o.row_req   = row_req;
  assign cut_o.row_idx   = row_idx_d;
  assign cut_o.we        = we_i;
  assign cut_o.word_addr = word_idx_d;
  assign cut_o.wdata     = col_wdata;
  assign cut_o.be        = col_be;

endmodule

// File: rtl/l2_sram_cut.sv
/*
  Behavioral single-port SRAM cut, stands in for the memory macro.
  A request writes the enabled bytes and also reads the same address,
  so the read data shows the old content one cycle later.
*/

module l2_sram_cut
  import l2_cut_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  logic      we_i,
  input  cut_addr_t addr_i,
  input  cut_data_t wdata_i,
  input  cut_strb_t be_i,
  output cut_data_t rdata_o
);

  cut_data_t mem_q [CUT_N_WORDS];
  cut_data_t rdata_q;

  // Byte-enabled write port
  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      for (int b = 0; b < CUT_STRB_W; b++) begin
        if (be_i[b]) begin
          mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
        end
      end
    end
  end

  // Output latch of the macro, keeps its value between requests
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

endmodule

// File: rtl/l2_cut_array.sv
/*
  Pipeline stage 2 of the scratchpad, the grid of SRAM cuts.
  Each row is enabled by its bit of the row request, every column takes
  its own data and strobe slice. Read data of all rows goes back on the
  response interface.
*/

`include "l2_mem_settings.svh"

module l2_cut_array
  import l2_arr_pkg::*;
  import l2_cut_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  l2_cut_req_if.dst cut_i,
  l2_cut_rsp_if.src rsp_o
);

  cut_row_data_t [N_SER_CUTS-1:0] cut_rdata;

  // Grid must tile the address space exactly
  if (!`L2_IS_POW2(N_PAR_CUTS) || !`L2_IS_POW2(N_SER_CUTS)) begin : gen_bad_grid
    $error("Cut grid is not a power of two in rows and columns");
  end
  if (ROW_IDX_OFF + ROW_IDX_W != ADDR_W) begin : gen_bad_addr
    $error("Address width does not match the cut grid");
  end

  for (genvar r = 0; r < N_SER_CUTS; r++) begin : gen_rows
    for (genvar c = 0; c < N_PAR_CUTS; c++) begin : gen_cols
      l2_sram_cut l2_sram_cut_i (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .req_i   (cut_i.row_req[r]),
        .we_i    (cut_i.we),
        .addr_i  (cut_i.word_addr),
        .wdata_i (cut_i.wdata[c]),
        .be_i    (cut_i.be[c]),
        .rdata_o (cut_rdata[r][c])
      );
    end
  end

  assign rsp_o.rdata = cut_rdata;

endmodule

// File: rtl/l2_read_return.sv
/*
  Pipeline stage 3 of the scratchpad.
  Registers whether a request was taken and which row it hit, then picks
  that row out of the array read data. Response valid trails the request
  by one cycle for reads and writes alike.
*/

module l2_read_return
  import l2_arr_pkg::*;
  import l2_cut_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  l2_cut_req_if.mon  cut_i,
  l2_cut_rsp_if.dst  rsp_i,
  output logic       rvalid_o,
  output arr_data_t  rdata_o
);

  logic          req;
  logic          req_q;
  row_idx_t      row_idx_q;
  cut_row_data_t row_rdata;

  // Row request is one-hot, any bit set means a request was taken
  assign req = |cut_i.row_req;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q     <= 1'b0;
      row_idx_q <= '0;
    end else begin
      req_q     <= req;
      row_idx_q <= cut_i.row_idx;
    end
  end

  // Cut outputs are registered, so they line up with row_idx_q
  assign row_rdata = rsp_i.rdata[row_idx_q];

  assign rvalid_o = req_q;
  assign rdata_o  = row_rdata;

endmodule

// File: rtl/l2_mem_top.sv
/*
  Top level of the L2 scratchpad memory.
  Plain request port, no grant: every cycle with req_i high is accepted
  and answered with rvalid_o one cycle later. rdata_o is only meaningful
  for reads.
*/

module l2_mem_top
  import l2_arr_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      req_i,
  input  logic      we_i,
  input  arr_addr_t addr_i,
  input  arr_data_t wdata_i,
  input  arr_strb_t be_i,
  output logic      rvalid_o,
  output arr_data_t rdata_o
);

  l2_cut_req_if cut_req_if ();
  l2_cut_rsp_if cut_rsp_if ();

  // Stage 1, address split and field hold
  l2_req_decode l2_req_decode_i (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (req_i),
    .we_i    (we_i),
    .addr_i  (addr_i),
    .wdata_i (wdata_i),
    .be_i    (be_i),
    .cut_o   (cut_req_if.src)
  );

  // Stage 2, cut grid
  l2_cut_array l2_cut_array_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .cut_i  (cut_req_if.dst),
    .rsp_o  (cut_rsp_if.src)
  );

  // Stage 3, row select and response
  l2_read_return l2_read_return_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .cut_i    (cut_req_if.mon),
    .rsp_i    (cut_rsp_if.dst),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o)
  );

endmodule

// File: bench/l2_mem_assert.sv
/*
  Concurrent checks on the scratchpad top level, attached with bind.
  Covers response timing, reset behavior and the decoded row request.
*/

module l2_mem_assert
  import l2_arr_pkg::*;
(
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  req_i,
  input logic                  rvalid_i,
  input logic [N_SER_CUTS-1:0] row_req_i
);

  // Number of assertion failures so far
  int unsigned fail_cnt = 0;

  // Response valid trails the request by exactly one cycle
  property p_rvalid_follows_req;
    @(posedge clk_i) disable iff (!rst_ni) rvalid_i == $past(req_i);
  endproperty

  property p_rvalid_low_in_reset;
    @(posedge clk_i) !rst_ni |-> !rvalid_i;
  endproperty

  // At most one row of cuts is ever enabled
  property p_row_req_onehot0;
    @(posedge clk_i) disable iff (!rst_ni) $onehot0(row_req_i);
  endproperty

  a_rvalid_follows_req: assert property (p_rvalid_follows_req)
    else begin
      $error("rvalid_o does not match req_i of the previous cycle");
      fail_cnt++;
    end
  a_rvalid_low_in_reset: assert property (p_rvalid_low_in_reset)
    else begin
      $error("rvalid_o is high during reset");
      fail_cnt++;
    end
  a_row_req_onehot0: assert property (p_row_req_onehot0)
    else begin
      $error("More than one cut row is requested");
      fail_cnt++;
    end

endmodule

bind l2_mem_top l2_mem_assert l2_mem_assert_i (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (req_i),
  .rvalid_i  (rvalid_o),
  .row_req_i (cut_req_if.row_req)
);

// File: bench/l2_mem_tb.sv
/*
  Testbench for the L2 scratchpad top level.
  Drives random traffic from an LFSR, keeps a byte-wide reference memory
  and checks every response in order. Prints one line per test and a summary.
*/

module l2_mem_tb
  import l2_arr_pkg::*;
();

  localparam int CLK_PERIOD    = 100;
  localparam int DRV_DLY       = 10;
  localparam int WORDS_PER_ROW = 16;
  localparam int SET_WORDS     = N_SER_CUTS * WORDS_PER_ROW;
  localparam int N_RANDOM_OPS  = 200;
  localparam int N_GAP_OPS     = 60;

  // Cycles of all tests, idle gaps counted at their worst case
  localparam int N_OPS      = 10 + 4 * SET_WORDS + N_RANDOM_OPS + 4 * N_GAP_OPS;
  localparam int WATCHDOG_T = N_OPS * CLK_PERIOD * 4 + 50 * CLK_PERIOD;

  typedef struct packed {
    logic      rd;
    arr_addr_t addr;
    arr_data_t data;
  } resp_t;

  logic      clk_i;
  logic      rst_ni;
  logic      req_i;
  logic      we_i;
  arr_addr_t addr_i;
  arr_data_t wdata_i;
  arr_strb_t be_i;
  logic      rvalid_o;
  arr_data_t rdata_o;

  logic [7:0]  ref_mem [2**ADDR_W];
  resp_t       exp_q [$];
  logic [15:0] lfsr_q = 16'd9670;
  logic        req_prev = 1'b0;
  string       test_name = "reset";
  int          err_cnt = 0;
  int          reads_cnt = 0;
  int          test_err0 = 0;
  int          test_reads0 = 0;
  int          failed_tests = 0;
  int          n_tests = 0;

  l2_mem_top l2_mem_top_i (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .be_i     (be_i),
    .rvalid_o (rvalid_o),
    .rdata_o  (rdata_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      r      = {r[62:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Words 0..7 and 56..63 of every row, so traffic keeps hitting written data
  function automatic arr_addr_t set_addr(input int i, input logic [2:0] off);
    row_idx_t  row;
    word_idx_t word;
    int        k;
    k    = i % WORDS_PER_ROW;
    row  = row_idx_t'(i / WORDS_PER_ROW);
    word = word_idx_t'((k < 8) ? k : k + 48);
    return {row, word, off};
  endfunction

  task automatic issue(input logic we, input arr_addr_t addr, input arr_data_t wdata,
                       input arr_strb_t be);
    resp_t     e;
    arr_addr_t base;
    @(posedge clk_i);
    #DRV_DLY;
    req_i   = 1'b1;
    we_i    = we;
    addr_i  = addr;
    wdata_i = wdata;
    be_i    = be;
    base    = addr & ~arr_addr_t'(STRB_W - 1);
    e.rd    = !we;
    e.addr  = base;
    e.data  = '0;
    for (int b = 0; b < STRB_W; b++) begin
      if (we) begin
        if (be[b]) begin
          ref_mem[base + arr_addr_t'(b)] = wdata[b*8 +: 8];
        end
      end else begin
        e.data[b*8 +: 8] = ref_mem[base + arr_addr_t'(b)];
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic idle_cycle();
    @(posedge clk_i);
    #DRV_DLY;
    req_i = 1'b0;
    we_i  = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_err0   = err_cnt;
    test_reads0 = reads_cnt;
  endtask

  // Let the last response come back, then report the test
  task automatic end_test();
    int errs;
    idle_cycle();
    @(posedge clk_i);
    if (exp_q.size() != 0) begin
      $display("Error: %s ended with %0d responses missing", test_name, exp_q.size());
      err_cnt++;
      exp_q.delete();
    end
    errs = err_cnt - test_err0;
    n_tests++;
    if (errs != 0) begin
      failed_tests++;
    end
    $display("%s: %s, %0d reads checked, %0d errors", test_name,
             (errs == 0) ? "pass" : "fail", reads_cnt - test_reads0, errs);
  endtask

  // Outputs are sampled on the falling edge, well away from the drive time
  always @(negedge clk_i) begin : monitor
    resp_t e;
    if (!rst_ni) begin
      if (rvalid_o !== 1'b0) begin
        $display("Error: %s rvalid_o is high while reset is asserted", test_name);
        err_cnt++;
      end
      req_prev = 1'b0;
    end else begin
      if (rvalid_o !== req_prev) begin
        $display("Error: %s rvalid_o is %0b but req_i one cycle earlier was %0b",
                 test_name, rvalid_o, req_prev);
        err_cnt++;
      end
      if (rvalid_o === 1'b1) begin
        if (exp_q.size() == 0) begin
          $display("Error: %s rvalid_o is high with no request outstanding", test_name);
          err_cnt++;
        end else begin
          e = exp_q.pop_front();
          if (e.rd) begin
            reads_cnt++;
            if (rdata_o !== e.data) begin
              $display("Error: %s read at 0x%03h expected 0x%016h actual 0x%016h",
                       test_name, e.addr, e.data, rdata_o);
              err_cnt++;
            end
          end
        end
      end
      req_prev = req_i;
    end
  end

  initial begin : watchdog
    #(WATCHDOG_T);
    $display("Error: the run did not finish within %0d time units", WATCHDOG_T);
    $display("Test FAILED");
    $finish;
  end

  initial begin : main
    logic      we;
    arr_addr_t addr;
    arr_data_t data;
    arr_strb_t be;
    int        gap;
    int        assert_errs;
    rst_ni  = 1'b0;
    req_i   = 1'b0;
    we_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;

    start_test("reset");
    repeat (5) @(posedge clk_i);
    #DRV_DLY;
    rst_ni = 1'b1;
    end_test();

    start_test("full_word");
    for (int i = 0; i < SET_WORDS; i++) begin
      data = rand_bits(64);
      issue(1'b1, set_addr(i, 3'b000), data, '1);
    end
    for (int i = 0; i < SET_WORDS; i++) begin
      addr = set_addr(i, 3'(rand_bits(3)));
      issue(1'b0, addr, '0, '0);
    end
    end_test();

    start_test("byte_strobe");
    for (int i = 0; i < SET_WORDS; i++) begin
      addr = set_addr(int'(rand_bits(6)), 3'(rand_bits(3)));
      data = rand_bits(64);
      be   = arr_strb_t'(rand_bits(8));
      issue(1'b1, addr, data, be);
    end
    for (int i = 0; i < SET_WORDS; i++) begin
      issue(1'b0, set_addr(i, 3'b000), '0, '0);
    end
    end_test();

    start_test("back_to_back");
    for (int i = 0; i < N_RANDOM_OPS; i++) begin
      we   = 1'(rand_bits(1));
      addr = set_addr(int'(rand_bits(6)), 3'(rand_bits(3)));
      data = rand_bits(64);
      be   = arr_strb_t'(rand_bits(8));
      issue(we, addr, data, be);
    end
    end_test();

    start_test("idle_gaps");
    for (int i = 0; i < N_GAP_OPS; i++) begin
      gap = int'(rand_bits(2));
      repeat (gap) idle_cycle();
      we   = 1'(rand_bits(1));
      addr = set_addr(int'(rand_bits(6)), 3'(rand_bits(3)));
      data = rand_bits(64);
      be   = arr_strb_t'(rand_bits(8));
      issue(we, addr, data, be);
    end
    end_test();

    assert_errs = int'(l2_mem_top_i.l2_mem_assert_i.fail_cnt);
    if (assert_errs != 0) begin
      $display("Error: %0d concurrent assertion failures were reported", assert_errs);
      err_cnt += assert_errs;
    end

    $display("Summary: %0d tests, %0d failed, %0d errors, %0d reads checked",
             n_tests, failed_tests, err_cnt, reads_cnt);
    if (err_cnt == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+rtl
rtl/l2_arr_pkg.sv
rtl/l2_cut_pkg.sv
rtl/l2_mem_if.sv
rtl/l2_req_decode.sv
rtl/l2_sram_cut.sv
rtl/l2_cut_array.sv
rtl/l2_read_return.sv
rtl/l2_mem_top.sv
bench/l2_mem_assert.sv
bench/l2_mem_tb.sv

// File: run.sh
#!/bin/sh
# Build the L2 scratchpad testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module l2_mem_tb -o l2_mem_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/l2_mem_sim > sim.log 2>&1
cat sim.log

grep -q "Test FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "Test OK" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation passed"
